// File: verilog/mempool_lite_pkg.sv
// Shared widths, system address map and boot image for the single-host memory system
// The testbench uses the same boot image as its reference
`default_nettype none

package mempool_lite_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

  // System address map, end addresses inclusive
  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4000_FFFF;
  localparam addr_t L2BaseAddr      = 32'h8000_0000; // End follows from the L2 geometry
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA000_FFFF;

  // One request address, seen as an L2 word or as a register page and offset
  typedef union packed {
    struct packed {
      logic [29:0] word_idx;
      logic [1:0]  byte_off;
    } l2;
    struct packed {
      logic [15:0] page;
      logic [15:0] offset; // Register index is offset / 4
    } regs;
  } mem_addr_u;

  localparam int unsigned CtrlNumRegs  = 16;
  localparam int unsigned CtrlIdxWidth = $clog2(CtrlNumRegs);

  localparam int unsigned RegEoc       = 0;
  localparam int unsigned RegWakeUp    = 1;
  localparam int unsigned RegTcdmStart = 2;
  localparam int unsigned RegTcdmEnd   = 3;
  localparam int unsigned RegNumCores  = 4;
  localparam int unsigned RegRoCacheEn = 5;

  localparam int unsigned BootromWords = 16;
  localparam data_t BootromImage [BootromWords] = '{
    32'h0000_0297, 32'h0202_8293, 32'h3052_9073, 32'hF140_2573,
    32'h4000_05B7, 32'h0045_8593, 32'h0005_A603, 32'h0006_0463,
    32'h1050_0073, 32'hFF5F_F06F, 32'h8000_0337, 32'h0003_0067,
    32'h0000_0013, 32'h0000_0013, 32'hDEAD_BEEF, 32'hC0DE_CAFE
  };

  // Byte-wise merge of new data into an old word under the strobes
  function automatic data_t apply_strb(data_t old_val, data_t new_val, strb_t strb);
    data_t res;
    res = old_val;
    for (int i = 0; i < StrbWidth; i++) begin
      if (strb[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

endpackage : mempool_lite_pkg

`default_nettype wire

// File: verilog/addr_decode_stage.sv
// Stage 1: address decode and request register, one request per cycle, no back-pressure
// L2 window end is exclusive, control and boot ROM windows end inclusive
`default_nettype none

module addr_decode_stage
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumL2Banks     = 4,
  parameter int unsigned L2BankNumWords = 64
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  logic      we_i,
  input  addr_t     addr_i,
  input  data_t     wdata_i,
  input  strb_t     strb_i,
  output logic      valid_o,
  output target_e   target_o,
  output mem_addr_u addr_o,
  output logic      we_o,
  output data_t     wdata_o,
  output strb_t     strb_o,
  output logic      err_o
);

  localparam addr_t L2EndAddr = L2BaseAddr + addr_t'(NumL2Banks * L2BankNumWords * 4);

  target_e   tgt_d;
  logic      err_d;
  logic      valid_q;
  target_e   target_q;
  logic      err_q;
  mem_addr_u addr_q;
  logic      we_q;
  data_t     wdata_q;
  strb_t     strb_q;

  always_comb begin
    if (addr_i >= CtrlBaseAddr && addr_i <= CtrlEndAddr) tgt_d = TgtCtrl;
    else if (addr_i >= L2BaseAddr && addr_i < L2EndAddr) tgt_d = TgtL2;
    else if (addr_i >= BootromBaseAddr && addr_i <= BootromEndAddr) tgt_d = TgtBootrom;
    else tgt_d = TgtNone;
  end

  // Unmapped access or write to read-only memory
  assign err_d = (tgt_d == TgtNone) || (tgt_d == TgtBootrom && we_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      target_q <= TgtNone;
      err_q    <= 1'b0;
    end else begin
      valid_q  <= req_i;
      target_q <= tgt_d;
      err_q    <= req_i && err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin // Payload only moves with a request
      addr_q  <= addr_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
      strb_q  <= strb_i;
    end
  end

  assign valid_o  = valid_q;
  assign target_o = target_q;
  assign err_o    = err_q;
  assign addr_o   = addr_q;
  assign we_o     = we_q;
  assign wdata_o  = wdata_q;
  assign strb_o   = strb_q;

endmodule : addr_decode_stage

`default_nettype wire

// File: verilog/l2_bank_array.sv
// Stage 2 L2 memory: word-interleaved single-port banks, NumL2Banks a power of two
// Read data is valid one cycle after the stage 1 request, contents are not reset
`default_nettype none

module l2_bank_array
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumL2Banks     = 4,
  parameter int unsigned L2BankNumWords = 64
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  target_e   target_i,
  input  mem_addr_u addr_i,
  input  logic      we_i,
  input  data_t     wdata_i,
  input  strb_t     strb_i,
  output data_t     rdata_o
);

  localparam int unsigned BankIdxW = (NumL2Banks > 1) ? $clog2(NumL2Banks) : 1;
  localparam int unsigned RowIdxW  = (L2BankNumWords > 1) ? $clog2(L2BankNumWords) : 1;

  logic                l2_access;
  logic [BankIdxW-1:0] bank_idx;
  logic [BankIdxW-1:0] bank_q;
  logic [RowIdxW-1:0]  row_idx;
  data_t               bank_rdata_q [NumL2Banks];

  assign l2_access = valid_i && (target_i == TgtL2);

  // Consecutive words go to consecutive banks
  assign bank_idx = BankIdxW'(addr_i.l2.word_idx % NumL2Banks);
  assign row_idx  = RowIdxW'(addr_i.l2.word_idx / NumL2Banks);

  for (genvar b = 0; b < NumL2Banks; b++) begin : gen_bank
    data_t mem_q [L2BankNumWords];
    logic  bank_en;

    assign bank_en = l2_access && (bank_idx == BankIdxW'(b)); // One bank per request

    always_ff @(posedge clk_i) begin
      if (bank_en) begin
        if (we_i) begin
          mem_q[row_idx] <= apply_strb(mem_q[row_idx], wdata_i, strb_i);
        end else begin
          bank_rdata_q[b] <= mem_q[row_idx];
        end
      end
    end
  end

  // Bank index follows the request so the right output is picked next cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bank_q <= '0;
    end else if (l2_access) begin
      bank_q <= bank_idx;
    end
  end

  assign rdata_o = bank_rdata_q[bank_q];

endmodule : l2_bank_array

`default_nettype wire

// File: verilog/bootrom_table.sv
// Stage 2 boot ROM: the image repeats every BootromWords words inside its window
// Writes are flagged in stage 1, the data captured for them is discarded
`default_nettype none

module bootrom_table
  import mempool_lite_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  target_e   target_i,
  input  mem_addr_u addr_i,
  output data_t     rdata_o
);

  localparam int unsigned RomIdxW = $clog2(BootromWords);

  logic [RomIdxW-1:0] rom_idx;
  logic               rom_access;
  data_t              rdata_q;

  assign rom_idx    = addr_i.l2.word_idx[RomIdxW-1:0]; // Word index modulo the image size
  assign rom_access = valid_i && (target_i == TgtBootrom);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rom_access) begin
      rdata_q <= BootromImage[rom_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule : bootrom_table

`default_nettype wire

// File: verilog/ctrl_regs.sv
// Stage 2 control registers, index = offset / 4, indices past CtrlNumRegs read zero
// NumCores must not exceed DataWidth, wake-up takes the low NumCores bits written
`default_nettype none

module ctrl_regs
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumCores     = 4,
  parameter addr_t       TCDMBaseAddr = 32'h0000_0000,
  parameter int unsigned TCDMSize     = 32'h0000_4000
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                valid_i,
  input  target_e             target_i,
  input  mem_addr_u           addr_i,
  input  logic                we_i,
  input  data_t               wdata_i,
  input  strb_t               strb_i,
  output data_t               rdata_o,
  output logic [NumCores-1:0] wake_up_o,
  output logic                eoc_valid_o,
  output logic                ro_cache_en_o
);

  localparam data_t TcdmEndAddr = TCDMBaseAddr + data_t'(TCDMSize);

  logic [CtrlIdxWidth-1:0] reg_idx;
  logic                    idx_hit;
  logic                    ctrl_access;
  data_t                   rd_val;
  data_t                   eoc_q;
  data_t                   ro_cache_q;
  logic [NumCores-1:0]     wake_up_q;
  data_t                   rdata_q;

  assign reg_idx     = addr_i.regs.offset[CtrlIdxWidth+1:2];
  assign idx_hit     = (addr_i.regs.offset[15:CtrlIdxWidth+2] == '0);
  assign ctrl_access = valid_i && (target_i == TgtCtrl);

  always_comb begin
    rd_val = '0;
    if (idx_hit) begin
      case (reg_idx)
        RegEoc:       rd_val = eoc_q;
        RegTcdmStart: rd_val = TCDMBaseAddr;
        RegTcdmEnd:   rd_val = TcdmEndAddr;
        RegNumCores:  rd_val = data_t'(NumCores);
        RegRoCacheEn: rd_val = ro_cache_q;
        default:      rd_val = '0; // Wake-up and spare indices
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      eoc_q      <= '0;
      ro_cache_q <= '0;
      wake_up_q  <= '0;
      rdata_q    <= '0;
    end else begin
      wake_up_q <= '0; // Pulse lasts a single cycle
      if (ctrl_access) begin
        rdata_q <= rd_val;
        if (we_i && idx_hit) begin
          case (reg_idx)
            RegEoc:       eoc_q      <= apply_strb(eoc_q, wdata_i, strb_i);
            RegWakeUp:    wake_up_q  <= wdata_i[NumCores-1:0];
            RegRoCacheEn: ro_cache_q <= apply_strb(ro_cache_q, wdata_i, strb_i);
            default:      ;
          endcase
        end
      end
    end
  end

  assign rdata_o       = rdata_q;
  assign wake_up_o     = wake_up_q;
  assign eoc_valid_o   = eoc_q[0];
  assign ro_cache_en_o = ro_cache_q[0];

endmodule : ctrl_regs

`default_nettype wire

// File: verilog/resp_merge_stage.sv
// Stage 3: response tags delayed one cycle to meet the stage 2 read data
// Read data is zero for writes, errors and idle cycles
`default_nettype none

module resp_merge_stage
  import mempool_lite_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    valid_i,
  input  target_e target_i,
  input  logic    err_i,
  input  logic    we_i,
  input  data_t   l2_rdata_i,
  input  data_t   rom_rdata_i,
  input  data_t   ctrl_rdata_i,
  output logic    rvalid_o,
  output data_t   rdata_o,
  output logic    rerr_o
);

  logic    valid_q;
  target_e target_q;
  logic    err_q;
  logic    we_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      target_q <= TgtNone;
      err_q    <= 1'b0;
      we_q     <= 1'b0;
    end else begin
      valid_q  <= valid_i;
      target_q <= target_i;
      err_q    <= valid_i && err_i;
      we_q     <= we_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (valid_q && !err_q && !we_q) begin
      case (target_q)
        TgtL2:      rdata_o = l2_rdata_i;
        TgtBootrom: rdata_o = rom_rdata_i;
        TgtCtrl:    rdata_o = ctrl_rdata_i;
        default:    rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = valid_q;
  assign rerr_o   = valid_q && err_q;

endmodule : resp_merge_stage

`default_nettype wire

// File: verilog/mempool_lite_system.sv
// Host memory system: every request answers two cycles later, no grant or back-pressure
// NumL2Banks must be a power of two, unmapped addresses return an error
`default_nettype none

module mempool_lite_system
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumL2Banks     = 4,
  parameter int unsigned L2BankNumWords = 64,
  parameter int unsigned NumCores       = 4,
  parameter addr_t       TCDMBaseAddr   = 32'h0000_0000,
  parameter int unsigned TCDMSize       = 32'h0000_4000
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  addr_t               addr_i,
  input  data_t               wdata_i,
  input  strb_t               strb_i,
  output logic                rvalid_o,
  output data_t               rdata_o,
  output logic                rerr_o,
  output logic [NumCores-1:0] wake_up_o,
  output logic                eoc_valid_o,
  output logic                ro_cache_en_o
);

  logic      s1_valid;
  target_e   s1_target;
  mem_addr_u s1_addr;
  logic      s1_we;
  data_t     s1_wdata;
  strb_t     s1_strb;
  logic      s1_err;
  data_t     l2_rdata;
  data_t     rom_rdata;
  data_t     ctrl_rdata;

  addr_decode_stage #(
    .NumL2Banks    (NumL2Banks    ),
    .L2BankNumWords(L2BankNumWords)
  ) i_addr_decode_stage (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .req_i   (req_i    ),
    .we_i    (we_i     ),
    .addr_i  (addr_i   ),
    .wdata_i (wdata_i  ),
    .strb_i  (strb_i   ),
    .valid_o (s1_valid ),
    .target_o(s1_target),
    .addr_o  (s1_addr  ),
    .we_o    (s1_we    ),
    .wdata_o (s1_wdata ),
    .strb_o  (s1_strb  ),
    .err_o   (s1_err   )
  );

  // Stage 2 targets all see the same request, each filters on its own target
  l2_bank_array #(
    .NumL2Banks    (NumL2Banks    ),
    .L2BankNumWords(L2BankNumWords)
  ) i_l2_bank_array (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .valid_i (s1_valid ),
    .target_i(s1_target),
    .addr_i  (s1_addr  ),
    .we_i    (s1_we    ),
    .wdata_i (s1_wdata ),
    .strb_i  (s1_strb  ),
    .rdata_o (l2_rdata )
  );

  bootrom_table i_bootrom_table (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .valid_i (s1_valid ),
    .target_i(s1_target),
    .addr_i  (s1_addr  ),
    .rdata_o (rom_rdata)
  );

  ctrl_regs #(
    .NumCores    (NumCores    ),
    .TCDMBaseAddr(TCDMBaseAddr),
    .TCDMSize    (TCDMSize    )
  ) i_ctrl_regs (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .valid_i      (s1_valid     ),
    .target_i     (s1_target    ),
    .addr_i       (s1_addr      ),
    .we_i         (s1_we        ),
    .wdata_i      (s1_wdata     ),
    .strb_i       (s1_strb      ),
    .rdata_o      (ctrl_rdata   ),
    .wake_up_o    (wake_up_o    ),
    .eoc_valid_o  (eoc_valid_o  ),
    .ro_cache_en_o(ro_cache_en_o)
  );

  resp_merge_stage i_resp_merge_stage (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .valid_i     (s1_valid  ),
    .target_i    (s1_target ),
    .err_i       (s1_err    ),
    .we_i        (s1_we     ),
    .l2_rdata_i  (l2_rdata  ),
    .rom_rdata_i (rom_rdata ),
    .ctrl_rdata_i(ctrl_rdata),
    .rvalid_o    (rvalid_o  ),
    .rdata_o     (rdata_o   ),
    .rerr_o      (rerr_o    )
  );

endmodule : mempool_lite_system

`default_nettype wire

// File: testbench/mempool_lite_system_props.sv
// Protocol checks bound into the system top: fixed two-cycle latency and wake-up pulse shape
// Holds only for a host that never sends two wake-up writes in consecutive cycles
`default_nettype none

module mempool_lite_system_props
  import mempool_lite_pkg::*;
#(
  parameter int unsigned NumCores = 4
) (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                req_i,
  input logic                rvalid_i,
  input logic                rerr_i,
  input data_t               rdata_i,
  input logic [NumCores-1:0] wake_up_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0; // Assertion failures so far

  // Every request answers exactly two cycles later
  resp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i == $past(req_i, 2))
    else begin
      fail_count++;
      $error("rvalid does not follow req by two cycles");
    end

  err_has_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i) rerr_i |-> rvalid_i)
    else begin
      fail_count++;
      $error("rerr raised without rvalid");
    end

  err_zero_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rerr_i |-> (rdata_i == '0))
    else begin
      fail_count++;
      $error("rdata is not zero on an error response");
    end

  wake_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wake_up_i != '0) |=> (wake_up_i == '0))
    else begin
      fail_count++;
      $error("wake_up pulse lasts longer than one cycle");
    end

endmodule : mempool_lite_system_props

bind mempool_lite_system mempool_lite_system_props #(.NumCores(NumCores)) i_props (
  .clk_i    (clk_i    ),
  .rst_n_i  (rst_n_i  ),
  .req_i    (req_i    ),
  .rvalid_i (rvalid_o ),
  .rerr_i   (rerr_o   ),
  .rdata_i  (rdata_o  ),
  .wake_up_i(wake_up_o)
);

`default_nettype wire

// File: testbench/tb_mempool_lite_system.sv
// Directed and random host requests checked against a model of L2, boot ROM and registers
// Runs the default geometry, every L2 word is written before it is read
`default_nettype none

module tb_mempool_lite_system
  import mempool_lite_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Cores     = 4;
  localparam addr_t       TcdmBase  = 32'h0000_0000;
  localparam int unsigned TcdmSize  = 32'h0000_4000;
  localparam int unsigned L2Words   = 4 * 64;
  localparam addr_t       L2EndAddr = L2BaseAddr + 4 * L2Words;
  localparam int unsigned NumRandom = 300;
  localparam int unsigned NumReqs   = L2Words + NumRandom + 80; // Directed tests stay below 80

  logic             clk_i;
  logic             rst_n_i;
  logic             req_i;
  logic             we_i;
  addr_t            addr_i;
  data_t            wdata_i;
  strb_t            strb_i;
  logic             rvalid_o;
  data_t            rdata_o;
  logic             rerr_o;
  logic [Cores-1:0] wake_up_o;
  logic             eoc_valid_o;
  logic             ro_cache_en_o;

  data_t       l2_model [L2Words];
  data_t       eoc_model;
  data_t       ro_model;
  logic [38:0] exp_q [$]; // {err, wake, eoc, ro, data} per pending response
  integer      seed = 72;
  int          checks = 0;
  int          errors = 0;
  int          test_num = 0;
  int          test_checks;
  int          test_errors;
  string       test_name;

  mempool_lite_system #(
    .NumL2Banks(4), .L2BankNumWords(64), .NumCores(Cores),
    .TCDMBaseAddr(TcdmBase), .TCDMSize(TcdmSize)
  ) i_mempool_lite_system (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
    data_t mask;
    for (int i = 0; i < 4; i++) mask[8*i +: 8] = {8{strb[i]}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic data_t fill_word(addr_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_A5A5;
  endfunction

  task automatic check_value(input string name, input data_t exp, input data_t got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Drives one request and queues the response the address map predicts
  task automatic issue(input logic we, input addr_t addr, input data_t wdata, input strb_t strb);
    data_t            rsp_data;
    logic             rsp_err;
    logic [Cores-1:0] rsp_wake;
    int unsigned      idx;
    rsp_data = '0;
    rsp_err  = 1'b0;
    rsp_wake = '0;
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    strb_i  <= strb;
    if (addr >= L2BaseAddr && addr < L2EndAddr) begin
      idx = (addr - L2BaseAddr) >> 2;
      if (we) l2_model[idx] = merge_bytes(l2_model[idx], wdata, strb);
      else rsp_data = l2_model[idx];
    end else if (addr >= CtrlBaseAddr && addr <= CtrlEndAddr) begin
      idx = addr[15:2];
      if (we && idx == RegEoc) eoc_model = merge_bytes(eoc_model, wdata, strb);
      if (we && idx == RegRoCacheEn) ro_model = merge_bytes(ro_model, wdata, strb);
      if (we && idx == RegWakeUp) rsp_wake = wdata[Cores-1:0];
      if (!we) begin
        case (idx)
          RegEoc:       rsp_data = eoc_model;
          RegTcdmStart: rsp_data = TcdmBase;
          RegTcdmEnd:   rsp_data = TcdmBase + TcdmSize;
          RegNumCores:  rsp_data = Cores;
          RegRoCacheEn: rsp_data = ro_model;
          default:      rsp_data = '0;
        endcase
      end
    end else if (addr >= BootromBaseAddr && addr <= BootromEndAddr) begin
      if (we) rsp_err = 1'b1;
      else rsp_data = BootromImage[(addr >> 2) % BootromWords];
    end else begin
      rsp_err = 1'b1;
    end
    exp_q.push_back({rsp_err, rsp_wake, eoc_model[0], ro_model[0], rsp_data});
  endtask

  task automatic start_test(input string name);
    test_num++;
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  // Idles the bus and waits for all pending responses
  task automatic finish_test();
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    $display("Test %0d %s: %0d checks, %0d errors", test_num, test_name,
             checks - test_checks, errors - test_errors);
  endtask

  always @(negedge clk_i) begin : monitor
    logic [38:0] exp;
    if (rst_n_i && rvalid_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Response at %0t ns arrived with no request pending", $time);
      end else begin
        exp = exp_q.pop_front();
        check_value("rerr_o", exp[38], rerr_o);
        check_value("wake_up_o", exp[37:34], wake_up_o);
        check_value("eoc_valid_o", exp[33], eoc_valid_o);
        check_value("ro_cache_en_o", exp[32], ro_cache_en_o);
        check_value("rdata_o", exp[31:0], rdata_o);
      end
    end else if (rst_n_i) begin
      check_value("wake_up_o", '0, wake_up_o); // Idle cycles carry no pulse
    end
  end

  initial begin
    #(NumReqs * 4 + 2000);
    $display("Watchdog expired with %0d responses still pending", exp_q.size());
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    int unsigned total_errors;
    int unsigned widx;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    strb_i    = '0;
    rst_n_i   = 1'b0;
    eoc_model = '0;
    ro_model  = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);

    start_test("reset_and_strobes");
    check_value("rdata_o", '0, rdata_o);
    check_value("status flags", '0, {rvalid_o, rerr_o, wake_up_o, eoc_valid_o, ro_cache_en_o});
    for (int i = 0; i < L2Words; i++) begin
      issue(1'b1, L2BaseAddr + 4 * i, fill_word(L2BaseAddr + 4 * i), 4'hF);
    end
    issue(1'b1, L2BaseAddr + 20, 32'hAABB_CCDD, 4'b0001);
    issue(1'b1, L2BaseAddr + 24, 32'h1122_3344, 4'b0110);
    issue(1'b1, L2BaseAddr + 28, 32'h5566_7788, 4'b1000);
    issue(1'b1, L2BaseAddr + 32, 32'hFFFF_FFFF, 4'b0000);
    issue(1'b1, L2BaseAddr + 36, 32'h9ABC_DEF0, 4'b1100);
    issue(1'b0, L2BaseAddr + 36, '0, '0); // Read right behind the write
    for (int i = 5; i < 9; i++) issue(1'b0, L2BaseAddr + 4 * i, '0, '0);
    finish_test();

    start_test("l2_random_stream");
    for (int n = 0; n < NumRandom; n++) begin
      widx = $unsigned($random(seed)) % L2Words;
      issue($random(seed) & 1, L2BaseAddr + 4 * widx, $random(seed), $random(seed));
    end
    finish_test();

    start_test("bootrom");
    for (int i = 0; i < 20; i++) issue(1'b0, BootromBaseAddr + 4 * i, '0, '0);
    issue(1'b0, BootromEndAddr - 3, '0, '0);
    issue(1'b1, BootromBaseAddr, 32'h1234_5678, 4'hF);
    issue(1'b1, BootromBaseAddr + 32'h40, 32'hFFFF_FFFF, 4'h3);
    finish_test();

    start_test("ctrl_regs");
    issue(1'b0, CtrlBaseAddr + 4 * RegTcdmStart, '0, '0);
    issue(1'b0, CtrlBaseAddr + 4 * RegTcdmEnd, '0, '0);
    issue(1'b0, CtrlBaseAddr + 4 * RegNumCores, '0, '0);
    issue(1'b1, CtrlBaseAddr + 4 * RegEoc, 32'h0000_0001, 4'b0001);
    issue(1'b0, CtrlBaseAddr + 4 * RegEoc, '0, '0);
    issue(1'b1, CtrlBaseAddr + 4 * RegRoCacheEn, 32'hFFFF_FF01, 4'b0001);
    issue(1'b1, CtrlBaseAddr + 4 * RegRoCacheEn, 32'h0000_A500, 4'b0010);
    issue(1'b0, CtrlBaseAddr + 4 * RegRoCacheEn, '0, '0);
    issue(1'b1, CtrlBaseAddr + 4 * RegEoc, 32'h0000_0000, 4'hF);
    issue(1'b1, CtrlBaseAddr + 32'h20, 32'hFFFF_FFFF, 4'hF); // Spare index ignores the write
    issue(1'b0, CtrlBaseAddr + 32'h20, '0, '0);
    issue(1'b0, CtrlBaseAddr + 32'h100, '0, '0);
    finish_test();

    start_test("wake_up");
    issue(1'b1, CtrlBaseAddr + 4 * RegWakeUp, 32'hFFFF_FFF5, 4'hF);
    issue(1'b0, CtrlBaseAddr + 4 * RegWakeUp, '0, '0);
    issue(1'b1, CtrlBaseAddr + 4 * RegWakeUp, 32'h0000_000A, 4'hF);
    finish_test();

    start_test("unmapped");
    issue(1'b0, L2EndAddr - 4, '0, '0);
    issue(1'b0, L2EndAddr, '0, '0);
    issue(1'b0, 32'h0000_0000, '0, '0);
    issue(1'b0, 32'h3FFF_FFFC, '0, '0);
    issue(1'b1, 32'h4001_0000, 32'h0000_0001, 4'hF);
    issue(1'b0, 32'h9000_0000, '0, '0);
    issue(1'b0, 32'hA001_0000, '0, '0);
    issue(1'b0, 32'hFFFF_FFFC, '0, '0);
    finish_test();

    total_errors = errors + i_mempool_lite_system.i_props.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_mempool_lite_system

`default_nettype wire

// File: mempool_lite.f
verilog/mempool_lite_pkg.sv
verilog/addr_decode_stage.sv
verilog/l2_bank_array.sv
verilog/bootrom_table.sv
verilog/ctrl_regs.sv
verilog/resp_merge_stage.sv
verilog/mempool_lite_system.sv
testbench/mempool_lite_system_props.sv
testbench/tb_mempool_lite_system.sv

// File: Bender.yml
package:
  name: mempool_lite

sources:
  - files:
      - verilog/mempool_lite_pkg.sv
      - verilog/addr_decode_stage.sv
      - verilog/l2_bank_array.sv
      - verilog/bootrom_table.sv
      - verilog/ctrl_regs.sv
      - verilog/resp_merge_stage.sv
      - verilog/mempool_lite_system.sv
  - target: test
    files:
      - testbench/mempool_lite_system_props.sv
      - testbench/tb_mempool_lite_system.sv
